// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := int_exec_unit_tb
RTL_TOP    := int_exec_unit
FLIST      := flist.f
OBJ_DIR    := obj_dir
PASS_MSG   := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
+incdir+include
source/int_unit_pkg.sv
source/int_operand_decode.sv
source/int_alu_core.sv
source/int_result_stage.sv
source/int_exec_unit.sv
sim/tb_clock_gen.sv
sim/int_exec_unit_tb.sv

// ==== include/int_unit_params.svh ====
// ------------------------------------------------
// Widths and RV64I encoding constants of the
// integer execute unit, included by the package
// and by every module that uses them
// ------------------------------------------------
`ifndef INT_UNIT_PARAMS_SVH
`define INT_UNIT_PARAMS_SVH

// Datapath widths
`define XLEN        64
`define VADDR_W     40
`define REG_ADDR_W  5
`define IMM12_W     12
`define IMM20_W     20
`define SHAMT_W     6
`define WORD_W      32

// Major opcodes, bits 6:2 of the opcode field
`define OPC_LUI     5'b01101
`define OPC_AUIPC   5'b00101

// funct7 codes
`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000

// funct3 codes
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// JAL/JALR link increment
`define LINK_OFFSET 4

`endif

// ==== sim/int_exec_unit_tb.sv ====
// ------------------------------------------------
// Testbench of the integer execute unit. Issues one
// request per cycle on the falling edge, predicts
// each result and checks it one cycle later
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "int_unit_params.svh"

module int_exec_unit_tb;
	import int_unit_pkg::*;

	// Expected outputs of one request
	typedef struct packed {
		xlen_t     result;
		reg_addr_t rd;
		logic      ready;
		vaddr_t    jalr_addr;
		logic      jalr_ready;
	} exp_out_t;

	localparam int CLK_PERIOD = 8;
	localparam int RR_REPS    = 4;
	localparam int IMM_REPS   = 4;
	// Idle, upper, jump and bad-encoding requests on top of the ALU loops
	localparam int N_TESTS    = RR_REPS * 20 + IMM_REPS * 18 + 20 + 16 + 12 + 9;

	logic       clk;
	logic       rst_n;
	issue_req_t issue;
	xlen_t      result;
	reg_addr_t  rd;
	logic       ready;
	vaddr_t     jalr_addr;
	logic       jalr_ready;

	exp_out_t    exp_q[$];
	logic [31:0] lfsr_state = 32'd42;
	int          n_pushed = 0;
	int          n_checked = 0;
	int          err_word = 0;
	int          err_reg = 0;
	int          err_addr = 0;
	int          err_bit = 0;

	tb_clock_gen tb_clock_gen_inst (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	int_exec_unit int_exec_unit_inst (
		.clk_i        (clk),
		.rst_n_i      (rst_n),
		.issue_i      (issue),
		.result_o     (result),
		.rd_o         (rd),
		.ready_o      (ready),
		.jalr_addr_o  (jalr_addr),
		.jalr_ready_o (jalr_ready)
	);

	// ------------------------------------------------
	// Random source, taps 32 22 2 1
	// ------------------------------------------------
	function automatic logic lfsr_next_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++)
			v = {v[62:0], lfsr_next_bit()};
		return v;
	endfunction

	// ------------------------------------------------
	// Reference model of the result rules
	// ------------------------------------------------
	function automatic exp_out_t ref_exec(input issue_req_t r);
		exp_out_t e;
		xlen_t    pc_x;
		xlen_t    imm_x;
		xlen_t    u_val;
		xlen_t    a;
		xlen_t    b;
		xlen_t    s;
		xlen_t    raw;
		shamt_t   sh;
		funct7_t  f7;
		logic     alt;
		logic     legal;
		e = '0;
		pc_x  = {{(`XLEN-`VADDR_W){r.pc[`VADDR_W-1]}}, r.pc};
		imm_x = {{(`XLEN-`IMM12_W){r.imm12[`IMM12_W-1]}}, r.imm12};
		u_val = {{(`XLEN-`IMM20_W-12){r.imm20[`IMM20_W-1]}}, r.imm20, 12'h000};
		if (r.jal_valid || r.jalr_valid) begin
			e.result     = pc_x + xlen_t'(`LINK_OFFSET);
			e.rd         = r.rd;
			e.ready      = 1'b1;
			e.jalr_ready = r.jalr_valid;
			if (r.jalr_valid) begin
				e.jalr_addr    = r.src1[`VADDR_W-1:0] + imm_x[`VADDR_W-1:0];
				e.jalr_addr[0] = 1'b0;
			end
		end else if (r.valid_opcode) begin
			// Other major opcodes keep rd but report nothing
			e.rd = r.rd;
			if (r.opcode[6:2] == `OPC_LUI) begin
				e.result = u_val;
				e.ready  = 1'b1;
			end else if (r.opcode[6:2] == `OPC_AUIPC) begin
				e.result = u_val + pc_x;
				e.ready  = 1'b1;
			end
		end else if (r.valid_inst) begin
			e.rd    = r.rd;
			e.ready = 1'b1;
			a = r.src1;
			b = r.is_imm ? imm_x : r.src2;
			if (r.is_word) begin
				a = {{(`XLEN-`WORD_W){1'b0}}, a[`WORD_W-1:0]};
				b = {{(`XLEN-`WORD_W){1'b0}}, b[`WORD_W-1:0]};
			end
			if (r.is_imm)
				sh = r.imm12[5:0];
			else if (r.is_word)
				sh = {1'b0, r.src2[4:0]};
			else
				sh = r.src2[5:0];
			// Immediate shifts carry shamt[5] in funct7 bit 0
			f7  = r.is_imm ? {r.funct7[6:1], 1'b0} : r.funct7;
			alt = (f7 == `F7_ALT);
			if (f7 == `F7_BASE)
				legal = 1'b1;
			else if (alt)
				legal = r.is_imm ? (r.funct3 != `F3_SLL) :
					(r.funct3 == `F3_ADD || r.funct3 == `F3_SR);
			else
				legal = r.is_imm && r.funct3 != `F3_SLL && r.funct3 != `F3_SR;
			raw = '0;
			s   = r.is_word ? {{(`XLEN-`WORD_W){a[`WORD_W-1]}}, a[`WORD_W-1:0]} : a;
			if (legal) begin
				case (r.funct3)
					`F3_ADD:  raw = (alt && !r.is_imm) ? a - b : a + b;
					`F3_SLL:  raw = a << sh;
					`F3_SLT:  raw = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
					`F3_SLTU: raw = (a < b) ? 64'd1 : 64'd0;
					`F3_XOR:  raw = a ^ b;
					`F3_SR:   raw = alt ? xlen_t'($signed(s) >>> sh) : a >> sh;
					`F3_OR:   raw = a | b;
					default:  raw = a & b;
				endcase
			end
			e.result = r.is_word ? {{(`XLEN-`WORD_W){raw[`WORD_W-1]}}, raw[`WORD_W-1:0]} : raw;
		end
		return e;
	endfunction

	// ------------------------------------------------
	// Compare tasks
	// ------------------------------------------------
	task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
			err_word++;
		end
	endtask

	task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
			err_reg++;
		end
	endtask

	task automatic check_addr(input string name, input vaddr_t got, input vaddr_t exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
			err_addr++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s got %b expected %b", $time, name, got, exp);
			err_bit++;
		end
	endtask

	task automatic compare_outputs(input exp_out_t e);
		check_word("result_o", result, e.result);
		check_reg("rd_o", rd, e.rd);
		check_bit("ready_o", ready, e.ready);
		check_addr("jalr_addr_o", jalr_addr, e.jalr_addr);
		check_bit("jalr_ready_o", jalr_ready, e.jalr_ready);
	endtask

	// ------------------------------------------------
	// Request builders
	// ------------------------------------------------
	task automatic send_request(input issue_req_t r);
		@(negedge clk);
		issue = r;
		exp_q.push_back(ref_exec(r));
		n_pushed++;
	endtask

	// Stale fields without a valid bit must not reach the outputs
	task automatic idle_cycle();
		issue_req_t r;
		r = '0;
		r.funct3 = funct3_t'(rand_bits(3));
		r.rd     = reg_addr_t'(rand_bits(5));
		r.src1   = rand_bits(64);
		r.imm12  = imm12_t'(rand_bits(12));
		r.pc     = vaddr_t'(rand_bits(40));
		send_request(r);
	endtask

	task automatic reg_reg_op(input funct3_t f3, input funct7_t f7, input logic word);
		issue_req_t r;
		r = '0;
		r.valid_inst = 1'b1;
		r.is_word    = word;
		r.opcode     = word ? 7'b0111011 : 7'b0110011;
		r.funct3     = f3;
		r.funct7     = f7;
		r.rd         = reg_addr_t'(rand_bits(5));
		r.src1       = rand_bits(64);
		r.src2       = rand_bits(64);
		send_request(r);
	endtask

	task automatic reg_imm_op(input funct3_t f3, input logic alt, input logic word,
		input int rep);
		issue_req_t r;
		shamt_t     sh;
		r = '0;
		r.valid_inst = 1'b1;
		r.is_imm     = 1'b1;
		r.is_word    = word;
		r.opcode     = word ? 7'b0011011 : 7'b0010011;
		r.funct3     = f3;
		r.rd         = reg_addr_t'(rand_bits(5));
		r.src1       = rand_bits(64);
		r.src2       = rand_bits(64);
		r.imm12      = imm12_t'(rand_bits(12));
		if (f3 == `F3_SLL || f3 == `F3_SR) begin
			// End points first, then random amounts
			sh = (rep == 0) ? '0 : shamt_t'(rand_bits(6));
			if (rep == 1)
				sh = '1;
			if (word)
				sh[5] = 1'b0;
			r.imm12 = {alt ? 6'b010000 : 6'b000000, sh};
		end
		r.funct7 = r.imm12[11:5];
		send_request(r);
	endtask

	task automatic upper_op(input opcode_t opc, input logic neg_pc);
		issue_req_t r;
		r = '0;
		r.valid_opcode = 1'b1;
		r.opcode       = opc;
		r.rd           = reg_addr_t'(rand_bits(5));
		r.src1         = rand_bits(64);
		r.imm20        = imm20_t'(rand_bits(20));
		r.pc           = vaddr_t'(rand_bits(40));
		r.pc[39]       = neg_pc;
		send_request(r);
	endtask

	task automatic jump_op(input logic is_jalr, input logic zero_rd);
		issue_req_t r;
		r = '0;
		r.jal_valid  = ~is_jalr;
		r.jalr_valid = is_jalr;
		r.opcode     = is_jalr ? 7'b1100111 : 7'b1101111;
		r.rd         = zero_rd ? '0 : reg_addr_t'(rand_bits(5));
		r.src1       = rand_bits(64);
		r.imm12      = imm12_t'(rand_bits(12));
		r.pc         = vaddr_t'(rand_bits(40));
		send_request(r);
	endtask

	// ------------------------------------------------
	// Stimulus and closing report
	// ------------------------------------------------
	initial begin
		int rep;
		int k;
		int w;
		issue = '0;
		wait (rst_n === 1'b1);
		// Reset values, before any clock edge after release
		compare_outputs('0);
		repeat (3) idle_cycle();
		// k 0..7 are the base funct3 codes, 8 is SUB, 9 is SRA
		for (rep = 0; rep < RR_REPS; rep++) begin
			for (w = 0; w < 2; w++) begin
				for (k = 0; k < 10; k++)
					reg_reg_op(k < 8 ? funct3_t'(k) : (k == 8 ? `F3_ADD : `F3_SR),
						k < 8 ? `F7_BASE : `F7_ALT, w[0]);
			end
		end
		idle_cycle();
		// k 5 is SRLI and k 8 is SRAI
		for (rep = 0; rep < IMM_REPS; rep++) begin
			for (w = 0; w < 2; w++) begin
				for (k = 0; k < 9; k++)
					reg_imm_op(k < 8 ? funct3_t'(k) : `F3_SR, k == 8, w[0], rep);
			end
		end
		idle_cycle();
		for (k = 0; k < 10; k++) begin
			upper_op({`OPC_LUI, 2'b11}, k[0]);
			upper_op({`OPC_AUIPC, 2'b11}, ~k[0]);
		end
		idle_cycle();
		for (k = 0; k < 8; k++) begin
			jump_op(1'b0, k == 0);
			jump_op(1'b1, k == 1);
		end
		idle_cycle();
		// M extension codes, then ALT funct7 on codes without an ALT form
		for (k = 0; k < 6; k++)
			reg_reg_op(k < 3 ? funct3_t'(rand_bits(3)) : funct3_t'(k - 2),
				k < 3 ? 7'b0000001 : `F7_ALT, k[0]);
		reg_imm_op(`F3_SLL, 1'b1, 1'b0, 2);
		reg_imm_op(`F3_SLL, 1'b1, 1'b1, 3);
		// Major opcodes other than LUI and AUIPC
		upper_op(7'b0110011, 1'b0);
		upper_op(7'b0010011, 1'b1);
		upper_op(7'b1100011, 1'b0);
		upper_op(7'b0000011, 1'b1);
		repeat (2) idle_cycle();
		wait (n_checked == n_pushed);
		$display("checks %0d, errors: result %0d, rd %0d, jalr_addr %0d, flags %0d",
			n_checked, err_word, err_reg, err_addr, err_bit);
		if (err_word + err_reg + err_addr + err_bit == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// Pops at the edge that samples a request, checks mid-cycle
	initial begin
		exp_out_t e;
		forever begin
			@(posedge clk);
			if (exp_q.size() > 0) begin
				e = exp_q.pop_front();
				@(negedge clk);
				compare_outputs(e);
				n_checked++;
			end
		end
	end

	initial begin
		#((N_TESTS + 20) * CLK_PERIOD * 2);
		$display("timeout: the run did not finish, %0d of %0d requests checked",
			n_checked, n_pushed);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
// ------------------------------------------------
// Testbench clock and reset source. 8 ns clock,
// active low reset held for the first 5 cycles
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
	output logic clk_o,
	output logic rst_n_o
);
	localparam int HALF_PERIOD  = 4;
	localparam int RESET_CYCLES = 5;

	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD clk_o = ~clk_o;
	end

	// Release on a falling edge, clear of the sampling edge
	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

// ==== source/int_alu_core.sv ====
// ------------------------------------------------
// Processing block of the execute unit. Computes
// the raw result of the decoded operation plus the
// JALR target, all combinational
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "int_unit_params.svh"

module int_alu_core (
	input  int_unit_pkg::exec_op_t  dec_op_i,
	output int_unit_pkg::exec_res_t alu_res_o
);
	import int_unit_pkg::*;

	xlen_t  sum;
	xlen_t  diff;
	xlen_t  sra_src;
	xlen_t  sra_res;
	xlen_t  link_val;
	xlen_t  raw;
	vaddr_t jalr_sum;
	logic   lt_s;
	logic   lt_u;

	// ------------------------------------------------
	// Shared arithmetic
	// ------------------------------------------------
	assign sum  = dec_op_i.opa + dec_op_i.opb;
	assign diff = dec_op_i.opa - dec_op_i.opb;
	assign lt_s = $signed(dec_op_i.opa) < $signed(dec_op_i.opb);
	assign lt_u = dec_op_i.opa < dec_op_i.opb;

	// Word SRA takes its sign from bit 31
	assign sra_src = dec_op_i.is_word ?
		{{(`XLEN-`WORD_W){dec_op_i.opa[`WORD_W-1]}}, dec_op_i.opa[`WORD_W-1:0]} :
		dec_op_i.opa;
	assign sra_res = xlen_t'($signed(sra_src) >>> dec_op_i.shamt);

	// Return address for JAL and JALR
	assign link_val = dec_op_i.pc_ext + xlen_t'(`LINK_OFFSET);

	// Target in 40-bit address space
	assign jalr_sum = dec_op_i.jalr_base + dec_op_i.jalr_off;

	// ------------------------------------------------
	// Result mux
	// ------------------------------------------------
	always_comb begin
		case (dec_op_i.op)
			ALU_ADD:   raw = sum;
			ALU_SUB:   raw = diff;
			ALU_SLL:   raw = dec_op_i.opa << dec_op_i.shamt;
			ALU_SLT:   raw = xlen_t'(lt_s);
			ALU_SLTU:  raw = xlen_t'(lt_u);
			ALU_XOR:   raw = dec_op_i.opa ^ dec_op_i.opb;
			ALU_SRL:   raw = dec_op_i.opa >> dec_op_i.shamt;
			ALU_SRA:   raw = sra_res;
			ALU_OR:    raw = dec_op_i.opa | dec_op_i.opb;
			ALU_AND:   raw = dec_op_i.opa & dec_op_i.opb;
			// opb holds the shifted U-immediate here
			ALU_LUI:   raw = dec_op_i.opb;
			ALU_AUIPC: raw = dec_op_i.pc_ext + dec_op_i.opb;
			ALU_LINK:  raw = link_val;
			// Illegal and none report zero
			default:   raw = '0;
		endcase
	end

	always_comb begin
		alu_res_o.raw       = raw;
		alu_res_o.sext_word = dec_op_i.is_word;
		alu_res_o.rd        = dec_op_i.rd;
		// Unknown opcode keeps rd but is not ready
		alu_res_o.active    = dec_op_i.active & (dec_op_i.op != ALU_NONE);
		alu_res_o.jalr      = dec_op_i.jalr;
		alu_res_o.jalr_target = dec_op_i.jalr ? {jalr_sum[`VADDR_W-1:1], 1'b0} : '0;
	end

endmodule

`default_nettype wire

// ==== source/int_exec_unit.sv ====
// ------------------------------------------------
// Top of the RV64I integer execute unit. Takes one
// decoded instruction per cycle and returns its
// registered result one cycle later
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module int_exec_unit (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  int_unit_pkg::issue_req_t issue_i,
	output int_unit_pkg::xlen_t      result_o,
	output int_unit_pkg::reg_addr_t  rd_o,
	output logic                     ready_o,
	output int_unit_pkg::vaddr_t     jalr_addr_o,
	output logic                     jalr_ready_o
);
	import int_unit_pkg::*;

	exec_op_t  dec_op;
	exec_res_t alu_res;

	// Decode and ALU in the issue cycle
	int_operand_decode int_operand_decode_inst (
		.issue_i  (issue_i),
		.dec_op_o (dec_op)
	);

	int_alu_core int_alu_core_inst (
		.dec_op_i  (dec_op),
		.alu_res_o (alu_res)
	);

	// Registered toward writeback
	int_result_stage int_result_stage_inst (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.alu_res_i    (alu_res),
		.result_o     (result_o),
		.rd_o         (rd_o),
		.ready_o      (ready_o),
		.jalr_addr_o  (jalr_addr_o),
		.jalr_ready_o (jalr_ready_o)
	);

endmodule

`default_nettype wire

// ==== source/int_operand_decode.sv ====
// ------------------------------------------------
// Input side of the execute unit. Maps the issued
// fields onto one ALU operation and prepares both
// operands, the shift amount and the JALR inputs
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "int_unit_params.svh"

module int_operand_decode (
	input  int_unit_pkg::issue_req_t issue_i,
	output int_unit_pkg::exec_op_t   dec_op_o
);
	import int_unit_pkg::*;

	xlen_t   src1_prep;
	xlen_t   src2_prep;
	xlen_t   imm12_ext;
	xlen_t   imm12_prep;
	xlen_t   imm20_ext;
	funct7_t imm_f7;
	alu_op_e reg_op;
	alu_op_e imm_op;
	alu_op_e op_sel;
	logic    counted;
	logic    jump;

	// ------------------------------------------------
	// Operand preparation
	// ------------------------------------------------
	// Word forms see only the low 32 bits, zero extended
	assign src1_prep = issue_i.is_word ?
		{{(`XLEN-`WORD_W){1'b0}}, issue_i.src1[`WORD_W-1:0]} : issue_i.src1;
	assign src2_prep = issue_i.is_word ?
		{{(`XLEN-`WORD_W){1'b0}}, issue_i.src2[`WORD_W-1:0]} : issue_i.src2;

	assign imm12_ext  = {{(`XLEN-`IMM12_W){issue_i.imm12[`IMM12_W-1]}}, issue_i.imm12};
	assign imm12_prep = issue_i.is_word ?
		{{(`XLEN-`WORD_W){1'b0}}, imm12_ext[`WORD_W-1:0]} : imm12_ext;
	// U-type value, already placed at bit 12
	assign imm20_ext  = {{(`XLEN-`IMM20_W-12){issue_i.imm20[`IMM20_W-1]}}, issue_i.imm20, 12'b0};

	// Shift immediates carry shamt[5] in funct7 bit 0
	assign imm_f7  = {issue_i.funct7[6:1], 1'b0};
	assign jump    = issue_i.jal_valid | issue_i.jalr_valid;
	assign counted = jump | issue_i.valid_opcode | issue_i.valid_inst;

	// ------------------------------------------------
	// Operation select
	// ------------------------------------------------
	// R-type
	always_comb begin
		reg_op = ALU_ILLEGAL;
		if (issue_i.funct7 == `F7_BASE) begin
			case (issue_i.funct3)
				`F3_ADD:  reg_op = ALU_ADD;
				`F3_SLL:  reg_op = ALU_SLL;
				`F3_SLT:  reg_op = ALU_SLT;
				`F3_SLTU: reg_op = ALU_SLTU;
				`F3_XOR:  reg_op = ALU_XOR;
				`F3_SR:   reg_op = ALU_SRL;
				`F3_OR:   reg_op = ALU_OR;
				default:  reg_op = ALU_AND;
			endcase
		end else if (issue_i.funct7 == `F7_ALT) begin
			if (issue_i.funct3 == `F3_ADD)
				reg_op = ALU_SUB;
			else if (issue_i.funct3 == `F3_SR)
				reg_op = ALU_SRA;
		end
	end

	// I-type, funct7 only matters for shifts
	always_comb begin
		case (issue_i.funct3)
			`F3_ADD:  imm_op = ALU_ADD;
			`F3_SLT:  imm_op = ALU_SLT;
			`F3_SLTU: imm_op = ALU_SLTU;
			`F3_XOR:  imm_op = ALU_XOR;
			`F3_OR:   imm_op = ALU_OR;
			`F3_AND:  imm_op = ALU_AND;
			`F3_SLL:  imm_op = (imm_f7 == `F7_BASE) ? ALU_SLL : ALU_ILLEGAL;
			default: begin
				if (imm_f7 == `F7_BASE)
					imm_op = ALU_SRL;
				else if (imm_f7 == `F7_ALT)
					imm_op = ALU_SRA;
				else
					imm_op = ALU_ILLEGAL;
			end
		endcase
	end

	// Jumps first, then opcode-only, then ALU instructions
	always_comb begin
		if (jump)
			op_sel = ALU_LINK;
		else if (issue_i.valid_opcode) begin
			if (issue_i.opcode[6:2] == `OPC_LUI)
				op_sel = ALU_LUI;
			else if (issue_i.opcode[6:2] == `OPC_AUIPC)
				op_sel = ALU_AUIPC;
			else
				op_sel = ALU_NONE;
		end else if (issue_i.valid_inst)
			op_sel = issue_i.is_imm ? imm_op : reg_op;
		else
			op_sel = ALU_NONE;
	end

	// ------------------------------------------------
	// Packed result for the ALU core
	// ------------------------------------------------
	always_comb begin
		dec_op_o.op      = op_sel;
		// Word handling only on the plain ALU path
		dec_op_o.is_word = issue_i.valid_inst & issue_i.is_word &
			~jump & ~issue_i.valid_opcode;
		dec_op_o.opa     = src1_prep;
		if (issue_i.valid_opcode)
			dec_op_o.opb = imm20_ext;
		else
			dec_op_o.opb = issue_i.is_imm ? imm12_prep : src2_prep;
		// Register word shifts use src2[4:0]
		if (issue_i.is_imm)
			dec_op_o.shamt = issue_i.imm12[`SHAMT_W-1:0];
		else if (issue_i.is_word)
			dec_op_o.shamt = {1'b0, issue_i.src2[4:0]};
		else
			dec_op_o.shamt = issue_i.src2[`SHAMT_W-1:0];
		dec_op_o.pc_ext    = {{(`XLEN-`VADDR_W){issue_i.pc[`VADDR_W-1]}}, issue_i.pc};
		dec_op_o.rd        = counted ? issue_i.rd : '0;
		dec_op_o.jalr      = issue_i.jalr_valid;
		dec_op_o.jalr_base = issue_i.src1[`VADDR_W-1:0];
		dec_op_o.jalr_off  = imm12_ext[`VADDR_W-1:0];
		dec_op_o.active    = counted;
	end

	// Issue never sends both jump kinds at once
	always_comb begin
		a_jump_excl: assert final (!(issue_i.jal_valid && issue_i.jalr_valid))
			else $error("jal_valid and jalr_valid high together");
	end

endmodule

`default_nettype wire

// ==== source/int_result_stage.sv ====
// ------------------------------------------------
// Output side of the execute unit. Sign extends
// word results and holds everything in one register
// stage toward writeback
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "int_unit_params.svh"

module int_result_stage (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  int_unit_pkg::exec_res_t  alu_res_i,
	output int_unit_pkg::xlen_t      result_o,
	output int_unit_pkg::reg_addr_t  rd_o,
	output logic                     ready_o,
	output int_unit_pkg::vaddr_t     jalr_addr_o,
	output logic                     jalr_ready_o
);
	import int_unit_pkg::*;

	xlen_t res_ext;

	// Word forms are sign extended from bit 31
	assign res_ext = alu_res_i.sext_word ?
		{{(`XLEN-`WORD_W){alu_res_i.raw[`WORD_W-1]}}, alu_res_i.raw[`WORD_W-1:0]} :
		alu_res_i.raw;

	// ------------------------------------------------
	// Writeback boundary register
	// ------------------------------------------------
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			result_o     <= '0;
			rd_o         <= '0;
			ready_o      <= 1'b0;
			jalr_addr_o  <= '0;
			jalr_ready_o <= 1'b0;
		end else begin
			result_o     <= res_ext;
			rd_o         <= alu_res_i.rd;
			ready_o      <= alu_res_i.active;
			jalr_addr_o  <= alu_res_i.jalr_target;
			jalr_ready_o <= alu_res_i.jalr;
		end
	end

	// Target alignment comes from the ALU core
	a_jalr_align: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		jalr_addr_o[0] == 1'b0)
		else $error("jalr_addr_o bit 0 set");

	// A JALR always writes its link value
	a_jalr_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		jalr_ready_o |-> ready_o)
		else $error("jalr_ready_o without ready_o");

endmodule

`default_nettype wire

// ==== source/int_unit_pkg.sv ====
// ------------------------------------------------
// Types shared by the integer execute unit and its
// testbench: field widths, the ALU op selector and
// the structs passed between the pipeline blocks
// ------------------------------------------------
`default_nettype none

`include "int_unit_params.svh"

package int_unit_pkg;

	// Field and datapath widths
	typedef logic [`XLEN-1:0]       xlen_t;
	typedef logic [`VADDR_W-1:0]    vaddr_t;
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [`IMM12_W-1:0]    imm12_t;
	typedef logic [`IMM20_W-1:0]    imm20_t;
	typedef logic [`SHAMT_W-1:0]    shamt_t;
	typedef logic [2:0]             funct3_t;
	typedef logic [6:0]             funct7_t;
	typedef logic [6:0]             opcode_t;

	// Operation picked by the decoder
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_LUI,
		ALU_AUIPC,
		ALU_LINK,
		// Known class, bad funct7
		ALU_ILLEGAL,
		// Nothing to report
		ALU_NONE
	} alu_op_e;

	// One issued instruction
	typedef struct packed {
		logic      valid_inst;
		logic      is_word;
		logic      is_imm;
		logic      valid_opcode;
		logic      jal_valid;
		logic      jalr_valid;
		opcode_t   opcode;
		funct3_t   funct3;
		funct7_t   funct7;
		reg_addr_t rd;
		xlen_t     src1;
		xlen_t     src2;
		imm12_t    imm12;
		imm20_t    imm20;
		vaddr_t    pc;
	} issue_req_t;

	// Decoder to ALU core
	typedef struct packed {
		alu_op_e   op;
		logic      is_word;
		xlen_t     opa;
		xlen_t     opb;
		shamt_t    shamt;
		xlen_t     pc_ext;
		reg_addr_t rd;
		logic      jalr;
		vaddr_t    jalr_base;
		vaddr_t    jalr_off;
		logic      active;
	} exec_op_t;

	// ALU core to result stage
	typedef struct packed {
		xlen_t     raw;
		logic      sext_word;
		reg_addr_t rd;
		logic      active;
		logic      jalr;
		vaddr_t    jalr_target;
	} exec_res_t;

endpackage

`default_nettype wire
